// ==== alu_pipe_top.f ====
common/mips_pkg.sv
common/decode_if.sv
hw/decode/instr_decoder.sv
hw/decode/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/alu_pipe_top.sv
test/alu_pipe_tb.sv

// ==== common/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
	import mips_pkg::*;

	logic valid;
	alu_op_t op;
	word_t a; // Rs value.
	word_t b; // Rt value or extended immediate.
	shamt_t shamt;
	logic var_shift;
	reg_idx_t dest;
	logic write;
	logic unsupported;

	modport producer (
		output valid, op, a, b, shamt, var_shift, dest, write, unsupported
	);

	modport consumer (
		input valid, op, a, b, shamt, var_shift, dest, write, unsupported
	);

endinterface

`default_nettype wire

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int WORD_W = 32;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI
	} alu_op_t;

	// Instruction word fields.
	localparam int F_OP_HI = 31, F_OP_LO = 26;
	localparam int F_RS_HI = 25, F_RS_LO = 21;
	localparam int F_RT_HI = 20, F_RT_LO = 16;
	localparam int F_RD_HI = 15, F_RD_LO = 11;
	localparam int F_SH_HI = 10, F_SH_LO = 6;
	localparam int F_FN_HI = 5, F_FN_LO = 0;
	localparam int F_IMM_HI = 15, F_IMM_LO = 0;

	localparam opcode_t OPC_SPECIAL  = 6'b000000;
	localparam opcode_t OPC_REGIMM   = 6'b000001;
	localparam opcode_t OPC_J        = 6'b000010;
	localparam opcode_t OPC_JAL      = 6'b000011;
	localparam opcode_t OPC_BEQ      = 6'b000100;
	localparam opcode_t OPC_BNE      = 6'b000101;
	localparam opcode_t OPC_BLEZ     = 6'b000110;
	localparam opcode_t OPC_BGTZ     = 6'b000111;
	localparam opcode_t OPC_ADDI     = 6'b001000;
	localparam opcode_t OPC_ADDIU    = 6'b001001;
	localparam opcode_t OPC_SLTI     = 6'b001010;
	localparam opcode_t OPC_SLTIU    = 6'b001011;
	localparam opcode_t OPC_ANDI     = 6'b001100;
	localparam opcode_t OPC_ORI      = 6'b001101;
	localparam opcode_t OPC_XORI     = 6'b001110;
	localparam opcode_t OPC_LUI      = 6'b001111;
	localparam opcode_t OPC_COP0     = 6'b010000;
	localparam opcode_t OPC_SPECIAL2 = 6'b011100;
	localparam opcode_t OPC_LB       = 6'b100000;
	localparam opcode_t OPC_LH       = 6'b100001;
	localparam opcode_t OPC_LW       = 6'b100011;
	localparam opcode_t OPC_LBU      = 6'b100100;
	localparam opcode_t OPC_LHU      = 6'b100101;
	localparam opcode_t OPC_SB       = 6'b101000;
	localparam opcode_t OPC_SH       = 6'b101001;
	localparam opcode_t OPC_SWL      = 6'b101010;
	localparam opcode_t OPC_SW       = 6'b101011;
	localparam opcode_t OPC_SWR      = 6'b101110;

	localparam funct_t FN_SLL   = 6'b000000;
	localparam funct_t FN_SRL   = 6'b000010;
	localparam funct_t FN_SRA   = 6'b000011;
	localparam funct_t FN_SLLV  = 6'b000100;
	localparam funct_t FN_SRLV  = 6'b000110;
	localparam funct_t FN_SRAV  = 6'b000111;
	localparam funct_t FN_JR    = 6'b001000;
	localparam funct_t FN_JALR  = 6'b001001;
	localparam funct_t FN_MOVZ  = 6'b001010;
	localparam funct_t FN_MOVN  = 6'b001011;
	localparam funct_t FN_MFHI  = 6'b010000;
	localparam funct_t FN_MTHI  = 6'b010001;
	localparam funct_t FN_MFLO  = 6'b010010;
	localparam funct_t FN_MTLO  = 6'b010011;
	localparam funct_t FN_MULT  = 6'b011000;
	localparam funct_t FN_MULTU = 6'b011001;
	localparam funct_t FN_DIV   = 6'b011010;
	localparam funct_t FN_DIVU  = 6'b011011;
	localparam funct_t FN_ADD   = 6'b100000;
	localparam funct_t FN_ADDU  = 6'b100001;
	localparam funct_t FN_SUB   = 6'b100010;
	localparam funct_t FN_SUBU  = 6'b100011;
	localparam funct_t FN_AND   = 6'b100100;
	localparam funct_t FN_OR    = 6'b100101;
	localparam funct_t FN_XOR   = 6'b100110;
	localparam funct_t FN_NOR   = 6'b100111;
	localparam funct_t FN_SLT   = 6'b101010;
	localparam funct_t FN_SLTU  = 6'b101011;

	// SPECIAL2 multiply-accumulate group.
	localparam funct_t FN_MADD  = 6'b000000;
	localparam funct_t FN_MADDU = 6'b000001;
	localparam funct_t FN_MSUB  = 6'b000100;
	localparam funct_t FN_MSUBU = 6'b000101;

	localparam reg_idx_t RT_BLTZ = 5'b00000;
	localparam reg_idx_t RT_BGEZ = 5'b00001;
	localparam reg_idx_t RS_MFC0 = 5'b00000;
	localparam reg_idx_t RS_MTC0 = 5'b00100;

	localparam word_t ERET_WORD = 32'h4200_0018;

endpackage

`default_nettype wire

// ==== hw/alu_pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_pipe_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  mips_pkg::word_t    instr,
	output logic               done_valid,
	output logic               done_write,
	output logic               done_unsupported,
	output mips_pkg::reg_idx_t done_reg,
	output mips_pkg::word_t    done_data
);
	import mips_pkg::*;

	alu_op_t op;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t dest;
	shamt_t shamt;
	logic imm_sel;
	logic imm_signed;
	logic var_shift;
	logic writes;
	logic supported;
	word_t rdata_a;
	word_t rdata_b;
	word_t ex_result;

	decode_if dx_bus ();

	instr_decoder instr_decoder_inst (
		.instr      (instr),
		.op         (op),
		.rs         (rs),
		.rt         (rt),
		.dest       (dest),
		.shamt      (shamt),
		.imm_sel    (imm_sel),
		.imm_signed (imm_signed),
		.var_shift  (var_shift),
		.writes     (writes),
		.supported  (supported)
	);

	decode_stage decode_stage_inst (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.op           (op),
		.rs           (rs),
		.rt           (rt),
		.dest         (dest),
		.shamt        (shamt),
		.imm_sel      (imm_sel),
		.imm_signed   (imm_signed),
		.var_shift    (var_shift),
		.writes       (writes),
		.supported    (supported),
		.instr        (instr),
		.rdata_a      (rdata_a),
		.rdata_b      (rdata_b),
		.fwd_ex_write (dx_bus.write), // Already qualified by valid.
		.fwd_ex_dest  (dx_bus.dest),
		.fwd_ex_data  (ex_result),
		.done_write   (done_write),
		.done_reg     (done_reg),
		.done_data    (done_data),
		.dx           (dx_bus.producer)
	);

	reg_file reg_file_inst (
		.clk     (clk),
		.reset   (reset),
		.raddr_a (rs),
		.raddr_b (rt),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.we      (done_write),
		.waddr   (done_reg),
		.wdata   (done_data)
	);

	execute_stage execute_stage_inst (
		.clk              (clk),
		.reset            (reset),
		.dx               (dx_bus.consumer),
		.ex_result        (ex_result),
		.done_valid       (done_valid),
		.done_write       (done_write),
		.done_unsupported (done_unsupported),
		.done_reg         (done_reg),
		.done_data        (done_data)
	);

endmodule

`default_nettype wire

// ==== hw/decode/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  mips_pkg::alu_op_t  op,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::reg_idx_t dest,
	input  mips_pkg::shamt_t   shamt,
	input  logic               imm_sel,
	input  logic               imm_signed,
	input  logic               var_shift,
	input  logic               writes,
	input  logic               supported,
	input  mips_pkg::word_t    instr,
	input  mips_pkg::word_t    rdata_a,
	input  mips_pkg::word_t    rdata_b,
	input  logic               fwd_ex_write,
	input  mips_pkg::reg_idx_t fwd_ex_dest,
	input  mips_pkg::word_t    fwd_ex_data,
	input  logic               done_write,
	input  mips_pkg::reg_idx_t done_reg,
	input  mips_pkg::word_t    done_data,
	decode_if.producer         dx
);
	import mips_pkg::*;

	imm_t imm;
	word_t imm_ext;
	word_t rs_val;
	word_t rt_val;

	assign imm = instr[F_IMM_HI:F_IMM_LO];
	assign imm_ext = imm_signed ? {{(WORD_W-16){imm[15]}}, imm} : {{(WORD_W-16){1'b0}}, imm};

	// Newest producer wins.
	always_comb begin
		if (fwd_ex_write && (fwd_ex_dest == rs))
			rs_val = fwd_ex_data;
		else if (done_write && (done_reg == rs))
			rs_val = done_data;
		else
			rs_val = rdata_a;

		if (fwd_ex_write && (fwd_ex_dest == rt))
			rt_val = fwd_ex_data;
		else if (done_write && (done_reg == rt))
			rt_val = done_data;
		else
			rt_val = rdata_b;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dx.valid <= 1'b0;
			dx.write <= 1'b0;
			dx.unsupported <= 1'b0;
		end else begin
			dx.valid <= instr_valid;
			dx.write <= instr_valid && writes && (dest != '0); // R0 writes are dropped.
			dx.unsupported <= instr_valid && !supported;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dx.op <= op;
			dx.a <= rs_val;
			dx.b <= imm_sel ? imm_ext : rt_val;
			dx.shamt <= shamt;
			dx.var_shift <= var_shift;
			dx.dest <= dest;
		end
	end

	assert property (@(posedge clk) disable iff (reset) dx.write |-> (dx.dest != '0));

endmodule

`default_nettype wire

// ==== hw/decode/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  mips_pkg::word_t    instr,
	output mips_pkg::alu_op_t  op,
	output mips_pkg::reg_idx_t rs,
	output mips_pkg::reg_idx_t rt,
	output mips_pkg::reg_idx_t dest,
	output mips_pkg::shamt_t   shamt,
	output logic               imm_sel,
	output logic               imm_signed,
	output logic               var_shift,
	output logic               writes,
	output logic               supported
);
	import mips_pkg::*;

	opcode_t opc;
	funct_t fn;
	reg_idx_t rd;
	logic other_form; // Recognized, but outside the ALU set.

	assign opc = instr[F_OP_HI:F_OP_LO];
	assign fn = instr[F_FN_HI:F_FN_LO];
	assign rs = instr[F_RS_HI:F_RS_LO];
	assign rt = instr[F_RT_HI:F_RT_LO];
	assign rd = instr[F_RD_HI:F_RD_LO];
	assign shamt = instr[F_SH_HI:F_SH_LO];

	always_comb begin
		op = OP_ADD;
		imm_sel = 1'b0;
		imm_signed = 1'b0;
		var_shift = 1'b0;
		supported = 1'b1;
		if (opc == OPC_SPECIAL) begin
			case (fn)
				FN_ADD, FN_ADDU: op = OP_ADD; // No overflow trap.
				FN_SUB, FN_SUBU: op = OP_SUB;
				FN_AND:  op = OP_AND;
				FN_OR:   op = OP_OR;
				FN_XOR:  op = OP_XOR;
				FN_NOR:  op = OP_NOR;
				FN_SLT:  op = OP_SLT;
				FN_SLTU: op = OP_SLTU;
				FN_SLL:  op = OP_SLL;
				FN_SRL:  op = OP_SRL;
				FN_SRA:  op = OP_SRA;
				FN_SLLV: begin
					op = OP_SLL;
					var_shift = 1'b1;
				end
				FN_SRLV: begin
					op = OP_SRL;
					var_shift = 1'b1;
				end
				FN_SRAV: begin
					op = OP_SRA;
					var_shift = 1'b1;
				end
				default: supported = 1'b0;
			endcase
		end else begin
			imm_sel = 1'b1;
			case (opc)
				OPC_ADDI, OPC_ADDIU: begin
					op = OP_ADD;
					imm_signed = 1'b1;
				end
				OPC_SLTI: begin
					op = OP_SLT;
					imm_signed = 1'b1;
				end
				OPC_SLTIU: begin
					op = OP_SLTU;
					imm_signed = 1'b1; // Sign extended, then compared unsigned.
				end
				OPC_ANDI: op = OP_AND;
				OPC_ORI:  op = OP_OR;
				OPC_XORI: op = OP_XOR;
				OPC_LUI:  op = OP_LUI;
				default: begin
					imm_sel = 1'b0;
					supported = 1'b0;
				end
			endcase
		end
	end

	assign dest = imm_sel ? rt : rd;
	assign writes = supported;

	always_comb begin
		other_form = 1'b0;
		case (opc)
			OPC_LB, OPC_LBU, OPC_LH, OPC_LHU, OPC_LW,
			OPC_SB, OPC_SH, OPC_SW, OPC_SWL, OPC_SWR,
			OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ,
			OPC_J, OPC_JAL: other_form = 1'b1;
			OPC_REGIMM: other_form = (rt == RT_BLTZ) || (rt == RT_BGEZ);
			OPC_SPECIAL2: other_form = fn inside {FN_MADD, FN_MADDU, FN_MSUB, FN_MSUBU};
			OPC_COP0: other_form = (rs == RS_MFC0) || (rs == RS_MTC0) || (instr == ERET_WORD);
			OPC_SPECIAL: other_form = fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
				FN_JR, FN_JALR, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO, FN_MOVZ, FN_MOVN};
			default: other_form = 1'b0;
		endcase
	end

	// Memory, branch, HI/LO and COP0 forms must never reach the ALU.
	always_comb begin
		assert (!(other_form && (supported || writes)));
	end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic               clk,
	input  logic               reset,
	decode_if.consumer         dx,
	output mips_pkg::word_t    ex_result,
	output logic               done_valid,
	output logic               done_write,
	output logic               done_unsupported,
	output mips_pkg::reg_idx_t done_reg,
	output mips_pkg::word_t    done_data
);
	import mips_pkg::*;

	shamt_t sh;
	word_t result;

	assign sh = dx.var_shift ? dx.a[4:0] : dx.shamt; // Only 5 bits of rs count.

	always_comb begin
		case (dx.op)
			OP_ADD:  result = dx.a + dx.b;
			OP_SUB:  result = dx.a - dx.b;
			OP_AND:  result = dx.a & dx.b;
			OP_OR:   result = dx.a | dx.b;
			OP_XOR:  result = dx.a ^ dx.b;
			OP_NOR:  result = ~(dx.a | dx.b);
			OP_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(dx.a) < $signed(dx.b)};
			OP_SLTU: result = {{(WORD_W-1){1'b0}}, dx.a < dx.b};
			OP_SLL:  result = dx.b << sh;
			OP_SRL:  result = dx.b >> sh;
			OP_SRA:  result = $signed(dx.b) >>> sh;
			OP_LUI:  result = {dx.b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign ex_result = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			done_valid <= 1'b0;
			done_write <= 1'b0;
			done_unsupported <= 1'b0;
		end else begin
			done_valid <= dx.valid;
			done_write <= dx.write;
			done_unsupported <= dx.unsupported;
		end
	end

	always_ff @(posedge clk) begin
		if (dx.valid) begin
			done_reg <= dx.dest;
			done_data <= dx.unsupported ? '0 : result;
		end
	end

	// Decode gates write with valid and support, so a retiring write is always a clean one.
	assert property (@(posedge clk) disable iff (reset)
		done_write |-> done_valid && !done_unsupported);

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::reg_idx_t raddr_a,
	input  mips_pkg::reg_idx_t raddr_b,
	output mips_pkg::word_t    rdata_a,
	output mips_pkg::word_t    rdata_b,
	input  logic               we,
	input  mips_pkg::reg_idx_t waddr,
	input  mips_pkg::word_t    wdata
);
	import mips_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// R0 is hardwired.
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f alu_pipe_top.f \
		--top-module alu_pipe_tb -o alu_pipe_sim \
	&& ./obj_dir/alu_pipe_sim | tee /dev/stderr | grep -qx "TESTS PASSED" \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation not ok"; exit 1; }

// ==== test/alu_pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_pipe_tb;
	import mips_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int N2 = 300;
	localparam int N3 = 200;
	localparam int N4 = 150;
	localparam int N5 = 120;
	localparam int N6 = 200;
	localparam int DRAIN = 6;
	localparam int ISSUE_MAX = 1 + 62 + N2 + N3 + 7 + N4 + N5 + 31 + N6 + 2 + 31;
	localparam int IDLE_MAX = RESET_CYCLES + 8 + 6 * DRAIN + 3 * N6;
	localparam int TIMEOUT = ISSUE_MAX + IDLE_MAX + 100;

	localparam funct_t R_FNS [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
		FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	localparam opcode_t I_OPCS [8] = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
		OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI};
	localparam funct_t SHIFT_FNS [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
	localparam opcode_t MEM_BR_OPCS [16] = '{OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU,
		OPC_SB, OPC_SH, OPC_SW, OPC_SWL, OPC_SWR, OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ,
		OPC_J, OPC_JAL};
	localparam funct_t HILO_FNS [10] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI,
		FN_MFLO, FN_MTHI, FN_MTLO, FN_JR, FN_JALR};

	typedef struct packed {
		logic unsup;
		logic write;
		reg_idx_t rd;
		word_t data;
		int due;
	} exp_t;

	logic clk;
	logic reset;
	logic instr_valid;
	word_t instr;
	logic done_valid;
	logic done_write;
	logic done_unsupported;
	reg_idx_t done_reg;
	word_t done_data;

	word_t model_regs [NUM_REGS];
	exp_t exp_q [$];
	int cycle;
	int issued;
	int checks;
	int errors;
	int test_err_base;

	alu_pipe_top alu_pipe_top_inst (
		.clk              (clk),
		.reset            (reset),
		.instr_valid      (instr_valid),
		.instr            (instr),
		.done_valid       (done_valid),
		.done_write       (done_write),
		.done_unsupported (done_unsupported),
		.done_reg         (done_reg),
		.done_data        (done_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic word_t r_form(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
		shamt_t sa);
		return {OPC_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_form(opcode_t opc, reg_idx_t rs, reg_idx_t rt, imm_t imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic reg_idx_t pick_reg(int lo, int hi);
		return reg_idx_t'($urandom_range(hi, lo));
	endfunction

	// ISA reference: returns 1 for the ALU subset, with dest and result.
	function automatic logic model_exec(input word_t w, output reg_idx_t d, output word_t r);
		reg_idx_t rs;
		reg_idx_t rt;
		shamt_t sa;
		word_t a;
		word_t b;
		word_t simm;
		word_t zimm;
		logic ok;
		rs = w[25:21];
		rt = w[20:16];
		sa = w[10:6];
		a = (rs == 5'd0) ? 32'h0 : model_regs[rs];
		b = (rt == 5'd0) ? 32'h0 : model_regs[rt];
		simm = {{16{w[15]}}, w[15:0]};
		zimm = {16'h0000, w[15:0]};
		ok = 1'b1;
		d = w[15:11];
		r = 32'h0;
		if (w[31:26] == OPC_SPECIAL) begin
			case (w[5:0])
				FN_ADD, FN_ADDU: r = a + b; // Wraps, no trap.
				FN_SUB, FN_SUBU: r = a - b;
				FN_AND:  r = a & b;
				FN_OR:   r = a | b;
				FN_XOR:  r = a ^ b;
				FN_NOR:  r = ~(a | b);
				FN_SLT:  r = {31'h0, $signed(a) < $signed(b)};
				FN_SLTU: r = {31'h0, a < b};
				FN_SLL:  r = b << sa;
				FN_SRL:  r = b >> sa;
				FN_SRA:  r = $signed(b) >>> sa;
				FN_SLLV: r = b << a[4:0];
				FN_SRLV: r = b >> a[4:0];
				FN_SRAV: r = $signed(b) >>> a[4:0];
				default: ok = 1'b0;
			endcase
		end else begin
			d = rt;
			case (w[31:26])
				OPC_ADDI, OPC_ADDIU: r = a + simm;
				OPC_SLTI:  r = {31'h0, $signed(a) < $signed(simm)};
				OPC_SLTIU: r = {31'h0, a < simm};
				OPC_ANDI:  r = a & zimm;
				OPC_ORI:   r = a | zimm;
				OPC_XORI:  r = a ^ zimm;
				OPC_LUI:   r = {w[15:0], 16'h0000};
				default:   ok = 1'b0;
			endcase
		end
		if (!ok)
			r = 32'h0;
		return ok;
	endfunction

	// Called on a falling edge, returns on the next one.
	task automatic issue(input word_t w);
		exp_t e;
		reg_idx_t d;
		word_t r;
		logic ok;
		ok = model_exec(w, d, r);
		e.unsup = !ok;
		e.write = ok && (d != 5'd0);
		e.rd = d;
		e.data = r;
		e.due = cycle + 2;
		if (e.write)
			model_regs[d] = r;
		exp_q.push_back(e);
		instr = w;
		instr_valid = 1'b1;
		issued++;
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic read_back_all();
		for (int i = 1; i < NUM_REGS; i++)
			issue(r_form(FN_OR, reg_idx_t'(i), 5'd0, reg_idx_t'(i), 5'd0));
	endtask

	task automatic end_test(input string name);
		while (exp_q.size() != 0)
			@(negedge clk);
		idle(2);
		if (errors == test_err_base)
			$display("%s: ok", name);
		else
			$display("%s: failed with %0d errors", name, errors - test_err_base);
		test_err_base = errors;
	endtask

	always @(negedge clk) begin : monitor
		exp_t e;
		if (!reset) begin
			if (done_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("Unexpected done_valid at %0t with no instruction outstanding",
						$time);
				end else begin
					e = exp_q.pop_front();
					check_value("latency cycle", cycle, e.due);
					check_value("done_unsupported", done_unsupported, e.unsup);
					check_value("done_write", done_write, e.write);
					check_value("done_data", done_data, e.data);
					if (!e.unsup)
						check_value("done_reg", done_reg, e.rd);
				end
			end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
				errors++;
				$display("No done_valid at %0t for the instruction due in cycle %0d",
					$time, exp_q[0].due);
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = 32'h0;
		cycle = 0;
		issued = 0;
		checks = 0;
		errors = 0;
		test_err_base = 0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = 32'h0;
		void'($urandom(12333));
		idle(RESET_CYCLES);
		reset = 1'b0;

		// Quiet pipeline after reset, then a zero-extended ori.
		repeat (8) begin
			@(negedge clk);
			check_value("idle done_valid", done_valid, 1'b0);
		end
		issue(i_form(OPC_ORI, 5'd0, 5'd1, 16'hbeef));
		end_test("test 1 reset and first ori");

		for (int i = 1; i < NUM_REGS; i++) begin
			issue(i_form(OPC_LUI, 5'd0, reg_idx_t'(i), imm_t'($urandom)));
			issue(i_form(OPC_ORI, reg_idx_t'(i), reg_idx_t'(i), imm_t'($urandom)));
		end
		for (int i = 0; i < N2; i++)
			issue(r_form(R_FNS[$urandom_range(15, 0)], pick_reg(0, 8), pick_reg(0, 8),
				pick_reg(1, 8), shamt_t'($urandom)));
		end_test("test 2 back-to-back register forms");

		for (int i = 0; i < N3; i++)
			issue(i_form(I_OPCS[$urandom_range(7, 0)], pick_reg(0, 8), pick_reg(0, 8),
				imm_t'($urandom)));
		end_test("test 3 immediate forms");

		issue(i_form(OPC_LUI, 5'd0, 5'd1, imm_t'($urandom) | 16'h8000)); // Negative.
		issue(i_form(OPC_ORI, 5'd1, 5'd1, imm_t'($urandom)));
		issue(i_form(OPC_LUI, 5'd0, 5'd2, imm_t'($urandom) & 16'h7fff));
		issue(i_form(OPC_ORI, 5'd2, 5'd2, imm_t'($urandom)));
		issue(i_form(OPC_ORI, 5'd0, 5'd3, imm_t'($urandom) | 16'h0020)); // Count above 31.
		issue(i_form(OPC_LUI, 5'd0, 5'd4, imm_t'($urandom)));
		issue(i_form(OPC_ORI, 5'd4, 5'd4, imm_t'($urandom)));
		for (int i = 0; i < N4; i++)
			issue(r_form(SHIFT_FNS[$urandom_range(5, 0)], pick_reg(1, 4), pick_reg(1, 4),
				pick_reg(5, 8), shamt_t'($urandom)));
		end_test("test 4 shifts");

		for (int i = 0; i < N5; i++) begin
			case ($urandom_range(7, 0))
				0: issue(i_form(MEM_BR_OPCS[$urandom_range(15, 0)], pick_reg(0, 31),
					pick_reg(0, 31), imm_t'($urandom)));
				1: issue(r_form(HILO_FNS[$urandom_range(9, 0)], pick_reg(0, 31),
					pick_reg(0, 31), pick_reg(0, 31), 5'd0));
				2: issue(i_form(OPC_REGIMM, pick_reg(0, 31),
					($urandom_range(1, 0) == 1) ? RT_BGEZ : RT_BLTZ, imm_t'($urandom)));
				3: issue({OPC_COP0, RS_MFC0, pick_reg(1, 31), pick_reg(0, 31), 11'h000});
				4: issue(ERET_WORD);
				5: issue({OPC_SPECIAL2, pick_reg(0, 31), pick_reg(0, 31), 10'h000, FN_MADD});
				default: issue({2'b11, 4'($urandom), 26'($urandom)}); // Unassigned opcodes.
			endcase
		end
		read_back_all();
		end_test("test 5 unsupported forms");

		for (int i = 0; i < N6; i++) begin
			if ($urandom_range(1, 0) == 1)
				issue(r_form(R_FNS[$urandom_range(15, 0)], pick_reg(0, 8), pick_reg(0, 8),
					5'd0, shamt_t'($urandom)));
			else
				issue(i_form(I_OPCS[$urandom_range(7, 0)], pick_reg(0, 8), 5'd0,
					imm_t'($urandom)));
			idle($urandom_range(3, 0));
		end
		issue(r_form(FN_ADDU, 5'd0, 5'd0, 5'd9, 5'd0));
		issue(i_form(OPC_ORI, 5'd0, 5'd10, 16'h0000));
		read_back_all();
		end_test("test 6 register 0 and strobe gaps");

		$display("Summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
